//--- source/lsuPkg.sv
package lsuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 4;
    localparam int memAddrWidth = 10;                   // Byte address
    localparam int memWords     = 2 ** (memAddrWidth - 1);
    localparam int regCount     = 2 ** regAddrWidth;

    typedef enum logic [2:0] {
        opLoadByte  = 3'd0,                             // Zero-extended
        opLoadWord  = 3'd1,
        opStoreByte = 3'd2,
        opStoreWord = 3'd3,
        opLoadImm   = 3'd4                              // Skips the memory array
    } memOp_t;

    // Command as it arrives from outside
    typedef struct packed {
        memOp_t                  op;
        logic [regAddrWidth-1:0] dest;
        logic [regAddrWidth-1:0] base;
        logic [regAddrWidth-1:0] src;
        logic [dataWidth-1:0]    offset;
    } lsuCmd_t;

    typedef struct packed {
        memOp_t                  op;
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    addr;
        logic [dataWidth-1:0]    data;                  // Store data or immediate
    } memStage_t;

    typedef struct packed {
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    data;
    } wbStage_t;

    typedef struct packed {
        logic [memAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } flashWr_t;

    // Ops that write a register at the end of the pipe
    function automatic logic isProducer(memOp_t op);
        return (op == opLoadByte) || (op == opLoadWord) || (op == opLoadImm);
    endfunction

    function automatic logic isStore(memOp_t op);
        return (op == opStoreByte) || (op == opStoreWord);
    endfunction

    // Base register feeds the address of every memory access
    function automatic logic usesBase(memOp_t op);
        return op != opLoadImm;
    endfunction

endpackage

//--- source/pipeReg.sv
module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     inReq,
    output logic     inAck,
    input  payload_t inData,

    output logic     outReq,
    input  logic     outAck,
    output payload_t outData
);

    logic     full;
    payload_t held;

    // Room when empty or when the held item leaves this edge
    assign inAck   = !full || outAck;
    assign outReq  = full;
    assign outData = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (inAck) begin
            full <= inReq;
        end
    end

    always_ff @(posedge clk) begin
        if (inReq && inAck) begin
            held <= inData;                 // Payload only, no reset
        end
    end

    // Producer side must not change or drop an item that was not taken
    stallHold: assert property (
        @(posedge clk) disable iff (rst)
        (outReq && !outAck) |=> (outReq && $stable(outData))
    );

endmodule

//--- source/regFile.sv
module regFile (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [lsuPkg::regAddrWidth-1:0]     rdAddrA,
    input  logic [lsuPkg::regAddrWidth-1:0]     rdAddrB,
    output logic [lsuPkg::dataWidth-1:0]        rdDataA,
    output logic [lsuPkg::dataWidth-1:0]        rdDataB,

    input  logic                                wrEn,
    input  logic [lsuPkg::regAddrWidth-1:0]     wrAddr,
    input  logic [lsuPkg::dataWidth-1:0]        wrData
);

    logic [lsuPkg::dataWidth-1:0] regs [lsuPkg::regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lsuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Bypass so a same-cycle write is visible to readers
    always_comb begin
        if (wrEn && wrAddr == rdAddrA) begin
            rdDataA = wrData;
        end else begin
            rdDataA = regs[rdAddrA];
        end
    end

    always_comb begin
        if (wrEn && wrAddr == rdAddrB) begin
            rdDataB = wrData;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

endmodule

//--- source/addrGen.sv
module addrGen (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                cmdReq,
    output logic                                cmdAck,
    input  lsuPkg::lsuCmd_t                     cmd,

    output logic [lsuPkg::regAddrWidth-1:0]     rdAddrA,
    output logic [lsuPkg::regAddrWidth-1:0]     rdAddrB,
    input  logic [lsuPkg::dataWidth-1:0]        rdDataA,
    input  logic [lsuPkg::dataWidth-1:0]        rdDataB,

    output logic                                memReq,
    input  logic                                memAck,
    output lsuPkg::memStage_t                   memData,

    input  logic [lsuPkg::regAddrWidth-1:0]     busyDestMem,
    input  logic                                busyMemValid,
    input  logic [lsuPkg::regAddrWidth-1:0]     busyDestWb,
    input  logic                                busyWbValid
);

    lsuPkg::memStage_t nextStage;
    logic              pipeInAck;
    logic              needBase;
    logic              needSrc;
    logic              hazard;

    assign rdAddrA = cmd.base;
    assign rdAddrB = cmd.src;

    always_comb begin
        nextStage.op   = cmd.op;
        nextStage.dest = cmd.dest;
        nextStage.addr = rdDataA + cmd.offset;          // Base plus offset
        if (cmd.op == lsuPkg::opLoadImm) begin
            nextStage.data = cmd.offset;
        end else begin
            nextStage.data = rdDataB;                   // Store data
        end
    end

    // Operands this command actually reads
    assign needBase = lsuPkg::usesBase(cmd.op);
    assign needSrc  = lsuPkg::isStore(cmd.op);

    function automatic logic clash(input logic busy, input logic [lsuPkg::regAddrWidth-1:0] dest,
                                   input logic useA, input logic useB,
                                   input lsuPkg::lsuCmd_t c);
        return busy && ((useA && dest == c.base) || (useB && dest == c.src));
    endfunction

    // Producers still ahead in the pipe, stores never count
    always_comb begin
        hazard = clash(memReq && lsuPkg::isProducer(memData.op), memData.dest,
                       needBase, needSrc, cmd);
        hazard = hazard || clash(busyMemValid, busyDestMem, needBase, needSrc, cmd);
        hazard = hazard || clash(busyWbValid, busyDestWb, needBase, needSrc, cmd);
    end

    assign cmdAck = pipeInAck && !hazard && !rst;       // Held low through reset

    pipeReg #(
        .payload_t (lsuPkg::memStage_t)
    ) u_memPipe (
        .clk     (clk),
        .rst     (rst),
        .inReq   (cmdReq && !hazard),
        .inAck   (pipeInAck),
        .inData  (nextStage),
        .outReq  (memReq),
        .outAck  (memAck),
        .outData (memData)
    );

endmodule

//--- source/dataMemory.sv
module dataMemory (
    input  logic              clk,
    input  logic              rst,

    // Flash loading
    input  logic              flashEn,
    input  lsuPkg::flashWr_t  flash,

    input  logic              memReq,
    output logic              memAck,
    input  lsuPkg::memStage_t memData,

    output logic              wbValid,
    output lsuPkg::wbStage_t  wbData,

    // Destination held in the access stage
    output logic [lsuPkg::regAddrWidth-1:0] busyDest,
    output logic              busyValid
);

    logic [lsuPkg::dataWidth-1:0]      mem [lsuPkg::memWords];
    lsuPkg::memStage_t                 stage;
    logic                              stageValid;
    logic                              stageIsStore;
    logic                              stageDrain;
    logic                              storeWr;
    logic                              wbInAck;
    logic [lsuPkg::memAddrWidth-2:0]   wordIdx;
    logic [lsuPkg::memAddrWidth-2:0]   wrIdx;
    logic [lsuPkg::dataWidth-1:0]      memRead;
    logic [lsuPkg::dataWidth-1:0]      storeValue;
    logic [lsuPkg::dataWidth-1:0]      wrValue;
    lsuPkg::wbStage_t                  wbNext;

    assign stageIsStore = lsuPkg::isStore(stage.op);

    // A store waits out a flash burst, loads leave when writeback has room
    assign stageDrain = stageIsStore ? !flashEn : wbInAck;
    assign memAck     = !flashEn && (!stageValid || stageDrain);

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else if (memReq && memAck) begin
            stageValid <= 1'b1;
        end else if (stageDrain) begin
            stageValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (memReq && memAck) begin
            stage <= memData;
        end
    end

    // Word index ignores address bit 0
    assign wordIdx = stage.addr[lsuPkg::memAddrWidth-1:1];
    assign memRead = mem[wordIdx];

    always_comb begin
        case (stage.op)
            lsuPkg::opStoreByte: storeValue = stage.addr[0] ?
                                              {stage.data[7:0], memRead[7:0]} :
                                              {memRead[15:8], stage.data[7:0]};
            default:             storeValue = stage.data;       // Store word
        endcase
    end

    assign storeWr = stageValid && stageIsStore && !flashEn;
    assign wrIdx   = flashEn ? flash.addr[lsuPkg::memAddrWidth-1:1] : wordIdx;
    assign wrValue = flashEn ? flash.data : storeValue;

    always_ff @(posedge clk) begin
        if (flashEn || storeWr) begin
            mem[wrIdx] <= wrValue;
        end
    end

    // Load alignment
    always_comb begin
        wbNext.dest = stage.dest;
        case (stage.op)
            lsuPkg::opLoadByte: wbNext.data = stage.addr[0] ? {8'h00, memRead[15:8]} :
                                                              {8'h00, memRead[7:0]};
            lsuPkg::opLoadWord: wbNext.data = memRead;
            default:            wbNext.data = stage.data;       // Immediate
        endcase
    end

    assign busyDest  = stage.dest;
    assign busyValid = stageValid && lsuPkg::isProducer(stage.op);

    pipeReg #(
        .payload_t (lsuPkg::wbStage_t)
    ) u_wbPipe (
        .clk     (clk),
        .rst     (rst),
        .inReq   (stageValid && !stageIsStore),
        .inAck   (wbInAck),
        .inData  (wbNext),
        .outReq  (wbValid),
        .outAck  (1'b1),                // Writeback never pushes back
        .outData (wbData)
    );

    // Flash owns the write port, a pending store keeps its place until it ends
    storeVsFlash: assert property (
        @(posedge clk) disable iff (rst)
        (stageValid && stageIsStore && flashEn) |=> (stageValid && $stable(stage))
    );

endmodule

//--- source/lsuTop.sv
module lsuTop (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                cmdReq,
    output logic                                cmdAck,
    input  lsuPkg::lsuCmd_t                     cmd,

    input  logic                                flashEn,
    input  lsuPkg::flashWr_t                    flash,

    output logic                                wbValid,
    output logic [lsuPkg::regAddrWidth-1:0]     wbReg,
    output logic [lsuPkg::dataWidth-1:0]        wbData
);

    logic [lsuPkg::regAddrWidth-1:0] rdAddrA;
    logic [lsuPkg::regAddrWidth-1:0] rdAddrB;
    logic [lsuPkg::dataWidth-1:0]    rdDataA;
    logic [lsuPkg::dataWidth-1:0]    rdDataB;
    logic                            memReq;
    logic                            memAck;
    lsuPkg::memStage_t               memData;
    lsuPkg::wbStage_t                wbOut;
    logic [lsuPkg::regAddrWidth-1:0] busyDestMem;
    logic                            busyMemValid;

    assign wbReg  = wbOut.dest;
    assign wbData = wbOut.data;

    addrGen u_addrGen (
        .clk          (clk),
        .rst          (rst),
        .cmdReq       (cmdReq),
        .cmdAck       (cmdAck),
        .cmd          (cmd),
        .rdAddrA      (rdAddrA),
        .rdAddrB      (rdAddrB),
        .rdDataA      (rdDataA),
        .rdDataB      (rdDataB),
        .memReq       (memReq),
        .memAck       (memAck),
        .memData      (memData),
        .busyDestMem  (busyDestMem),
        .busyMemValid (busyMemValid),
        .busyDestWb   (wbOut.dest),     // Writeback stage occupant
        .busyWbValid  (wbValid)
    );

    dataMemory u_dataMemory (
        .clk       (clk),
        .rst       (rst),
        .flashEn   (flashEn),
        .flash     (flash),
        .memReq    (memReq),
        .memAck    (memAck),
        .memData   (memData),
        .wbValid   (wbValid),
        .wbData    (wbOut),
        .busyDest  (busyDestMem),
        .busyValid (busyMemValid)
    );

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wbValid),
        .wrAddr  (wbOut.dest),
        .wrData  (wbOut.data)
    );

endmodule

//--- verif/lsuTb.sv
module lsuTb;

    logic                            clk;
    logic                            rst;
    logic                            cmdReq;
    logic                            cmdAck;
    lsuPkg::lsuCmd_t                 cmd;
    logic                            flashEn;
    lsuPkg::flashWr_t                flash;
    logic                            wbValid;
    logic [lsuPkg::regAddrWidth-1:0] wbReg;
    logic [lsuPkg::dataWidth-1:0]    wbData;

    integer                          seed;
    logic [lsuPkg::dataWidth-1:0]    refMem [lsuPkg::memWords];
    logic [lsuPkg::dataWidth-1:0]    refRegs [lsuPkg::regCount];
    lsuPkg::wbStage_t                expQ [$];
    lsuPkg::wbStage_t                expHead;       // Oldest expected writeback
    logic                            expAvail;

    lsuTop u_dut (.clk(clk), .rst(rst), .cmdReq(cmdReq), .cmdAck(cmdAck), .cmd(cmd),
        .flashEn(flashEn), .flash(flash), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    resetNoAck: assert property (@(posedge clk) rst |-> !cmdAck)
        else failRun("command acknowledge high while reset is active");
    resetQuiet: assert property (@(posedge clk) rst |=> (!wbValid && !u_dut.memReq))
        else failRun("writeback or memory request active right after a reset edge");
    flashHoldsMem: assert property (@(posedge clk) disable iff (rst) flashEn |-> !u_dut.memAck)
        else failRun("memory stage took an item during a flash write");
    wbExpected: assert property (@(posedge clk) disable iff (rst) wbValid |-> expAvail)
        else failRun("writeback arrived with no expected entry left");
    wbMatch: assert property (@(posedge clk) disable iff (rst)
        (wbValid && expAvail) |-> (wbReg == expHead.dest && wbData == expHead.data))
        else failRun($sformatf("mismatch at %0t: got r%0d = %h, expected r%0d = %h",
                               $time, wbReg, wbData, expHead.dest, expHead.data));

    // Nonblocking so every check at this edge still sees the old head
    task automatic refreshHead();
        expAvail <= (expQ.size() > 0);
        if (expQ.size() > 0) begin
            expHead <= expQ[0];
        end
    endtask

    always @(posedge clk) begin : popWriteback
        if (!rst && wbValid && expQ.size() > 0) begin
            expQ.delete(0);
            refreshHead();
        end
    end

    function automatic lsuPkg::lsuCmd_t makeCmd(input lsuPkg::memOp_t op,
            input logic [3:0] dest, input logic [3:0] base, input logic [3:0] src,
            input logic [15:0] offset);
        lsuPkg::lsuCmd_t c;
        c.op     = op;
        c.dest   = dest;
        c.base   = base;
        c.src    = src;
        c.offset = offset;
        return c;
    endfunction

    // Program order model, runs at the edge that accepts the command
    task automatic applyModel(input lsuPkg::lsuCmd_t c);
        logic [lsuPkg::dataWidth-1:0]    addr;
        logic [lsuPkg::memAddrWidth-2:0] idx;
        lsuPkg::wbStage_t                e;
        addr   = refRegs[c.base] + c.offset;
        idx    = addr[lsuPkg::memAddrWidth-1:1];    // Bit 0 only picks the lane
        e.dest = c.dest;
        e.data = '0;
        case (c.op)
            lsuPkg::opLoadImm:  e.data = c.offset;
            lsuPkg::opLoadWord: e.data = refMem[idx];
            lsuPkg::opLoadByte: e.data = addr[0] ? {8'h00, refMem[idx][15:8]} :
                                                   {8'h00, refMem[idx][7:0]};
            lsuPkg::opStoreByte: begin
                if (addr[0]) begin
                    refMem[idx][15:8] = refRegs[c.src][7:0];   // Odd address, high lane
                end else begin
                    refMem[idx][7:0] = refRegs[c.src][7:0];
                end
            end
            default: refMem[idx] = refRegs[c.src];
        endcase
        if (c.op != lsuPkg::opStoreByte && c.op != lsuPkg::opStoreWord) begin
            refRegs[c.dest] = e.data;
            expQ.push_back(e);
            refreshHead();
        end
    endtask

    task automatic issue(input lsuPkg::lsuCmd_t c);
        int waited;
        waited = 0;
        @(negedge clk);
        cmdReq = 1'b1;
        cmd    = c;
        @(posedge clk);
        while (!cmdAck) begin
            waited++;
            if (waited > 200) begin
                failRun("timeout waiting for a command to be accepted");
            end
            @(posedge clk);
        end
        applyModel(c);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        cmdReq = 1'b0;
        while (expQ.size() > 0) begin
            waited++;
            if (waited > 200) begin
                failRun("timeout waiting for outstanding writebacks");
            end
            @(negedge clk);
        end
        repeat (4) @(negedge clk);                  // Trailing stores land
    endtask

    task automatic flashWord(input logic [9:0] addr, input logic [15:0] data);
        @(negedge clk);
        flashEn    = 1'b1;
        flash.addr = addr;
        flash.data = data;
        refMem[addr[9:1]] = data;
    endtask

    task automatic endFlash();
        @(negedge clk);
        flashEn = 1'b0;
    endtask

    // Bases stay r0, addresses stay inside the flashed 32 words
    task automatic randomAccess(output lsuPkg::lsuCmd_t c);
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0, 3'd6: c.op = lsuPkg::opLoadByte;
            3'd1, 3'd5: c.op = lsuPkg::opLoadWord;
            3'd2:       c.op = lsuPkg::opStoreByte;
            3'd3, 3'd7: c.op = lsuPkg::opStoreWord;
            default:    c.op = lsuPkg::opLoadImm;
        endcase
        c.dest   = (r[6:3] < 4'd2) ? r[6:3] + 4'd8 : r[6:3];
        c.base   = 4'd0;
        c.src    = r[10:7];
        c.offset = (c.op == lsuPkg::opLoadImm) ? r[31:16] : {10'd0, r[16:11]};
    endtask

    initial begin
        lsuPkg::lsuCmd_t c;
        logic [31:0]     r;
        logic [31:0]     fr;
        int              burst;
        seed     = 32'h5062_af59;
        rst      = 1'b1;
        cmdReq   = 1'b0;
        cmd      = '0;
        flashEn  = 1'b0;
        flash    = '0;
        expAvail = 1'b0;
        expHead  = '0;
        for (int i = 0; i < lsuPkg::regCount; i++) begin
            refRegs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Cleared registers seen through an immediate and an untouched base
        flashWord(10'd0, 16'h3c5a);
        endFlash();
        issue(makeCmd(lsuPkg::opLoadImm, 4'd3, 4'd0, 4'd0, 16'hbeef));
        issue(makeCmd(lsuPkg::opLoadWord, 4'd4, 4'd9, 4'd0, 16'h0000));
        drain();

        for (int k = 0; k < 32; k++) begin
            r = $random(seed);
            flashWord(10'(2 * k), r[15:0]);
        end
        endFlash();
        for (int k = 0; k < 32; k++) begin
            issue(makeCmd(lsuPkg::opLoadWord, 4'(2 + k % 14), 4'd0, 4'd0, 16'(2 * k)));
            issue(makeCmd(lsuPkg::opLoadByte, 4'(3 + k % 13), 4'd0, 4'd0, 16'(2 * k)));
            issue(makeCmd(lsuPkg::opLoadByte, 4'(2 + k % 14), 4'd0, 4'd0, 16'(2 * k + 1)));
        end
        drain();

        repeat (80) begin
            randomAccess(c);
            issue(c);
        end
        for (int k = 0; k < 32; k++) begin
            issue(makeCmd(lsuPkg::opLoadWord, 4'(2 + k % 14), 4'd0, 4'd0, 16'(2 * k)));
        end
        drain();

        // Consumers right behind the producer of their base or source
        repeat (10) begin
            r = $random(seed);
            issue(makeCmd(lsuPkg::opLoadImm, 4'd1, 4'd0, 4'd0, {11'd0, r[4:0]}));
            issue(makeCmd(lsuPkg::opLoadWord, 4'd8, 4'd1, 4'd0, {11'd0, r[9:5]}));
            issue(makeCmd(lsuPkg::opLoadImm, 4'd6, 4'd0, 4'd0, r[31:16]));
            issue(makeCmd(lsuPkg::opStoreByte, 4'd0, 4'd1, 4'd6, {11'd0, r[14:10]}));
            issue(makeCmd(lsuPkg::opStoreWord, 4'd0, 4'd1, 4'd6, {11'd0, r[19:15]}));
            issue(makeCmd(lsuPkg::opLoadWord, 4'd7, 4'd1, 4'd0, {11'd0, r[14:10]}));
        end
        drain();

        // Flash bursts into the upper half while commands stream
        fork
            begin
                repeat (80) begin
                    randomAccess(c);
                    issue(c);
                end
                @(negedge clk);
                cmdReq = 1'b0;
            end
            begin
                repeat (8) begin
                    fr    = $random(seed);
                    burst = 1 + fr[4:3];
                    repeat (2 + fr[2:0]) @(negedge clk);
                    for (int k = 0; k < burst; k++) begin
                        flashWord(10'd600 + 10'(2 * k), fr[31:16]);
                    end
                    endFlash();
                end
            end
        join
        drain();

        if (expQ.size() != 0) begin
            failRun("writebacks still outstanding at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
source/lsuPkg.sv
source/pipeReg.sv
source/regFile.sv
source/addrGen.sv
source/dataMemory.sv
source/lsuTop.sv
verif/lsuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log

rm -f sim.log
verilator --binary --timing --assert --top-module lsuTb -f vlog.f -o lsuSim > build.log 2>&1 \
    && ./obj_dir/lsuSim > sim.log 2>&1 \
    || echo "TEST FAILED: build or simulation error, see build.log" >> sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
